// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

   // 16-bit instruction word and word-addressed pc
   typedef logic [15:0] inst_t;
   typedef logic [15:0] pc_t;

   // opcode field is the top nibble
   localparam int op_msb = 15;
   localparam int op_lsb = 12;

   // jump has every opcode bit set
   localparam logic [3:0] jump_op = 4'hf;

   // conditional branch: class bits 10, condition bits nonzero
   localparam logic [1:0] br_class = 2'b10;

   localparam inst_t nop_inst = '0;

   function automatic logic is_jump(input inst_t w);
      return w[op_msb:op_lsb] == jump_op;
   endfunction

   // condition field of zero is not a branch
   function automatic logic is_branch(input inst_t w);
      return (w[op_msb -: 2] == br_class) && (|w[op_lsb +: 2]);
   endfunction

endpackage

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

   import isa_pkg::*;

   // slots per fetch group
   localparam int fetch_width = 4;

   // unresolved branches allowed in flight
   localparam int max_branches = 2;

   // one bit per slot, bit 0 is the oldest
   typedef logic [fetch_width-1:0] slot_mask_t;

   // bit 1 first branch of the group, bit 0 second and later
   typedef logic [1:0] pred_t;

   typedef logic [1:0] br_cnt_t;

   // bundle from the cache side
   typedef struct packed {
      pc_t                       pc;
      inst_t [fetch_width-1:0]   inst;
      pred_t                     pred;
   } fetch_bundle_t;

   // filtered group toward decode
   typedef struct packed {
      pc_t                       pc;
      inst_t [fetch_width-1:0]   inst;
      slot_mask_t                taken;
      slot_mask_t                upd;
   } dispatch_t;

   // branch commit pulse from the reorder buffer
   typedef struct packed {
      logic decr;
      logic mispred_two;
   } commit_t;

endpackage

`default_nettype wire

// File: rtl/fetch_bundle_in.sv
`default_nettype none

module fetch_bundle_in
   import fetch_pkg::*;
(
   input  wire logic    clk,
   input  wire logic    rst_n,
   input  wire logic    in_valid,
   input  fetch_bundle_t in_bundle,
   output logic         in_ready,
   input  wire logic    take,
   output logic         held_valid,
   output fetch_bundle_t held_bundle
);

   logic full;
   logic load;

   // open when empty, or when the handler drains this cycle
   assign in_ready   = !full || take;
   assign load       = in_valid && in_ready;
   assign held_valid = full;

   ////////////////////////////////////////
   // full flag
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full <= 1'b0;
      end else if (load) begin
         // refill, possibly in the drain cycle
         full <= 1'b1;
      end else if (take) begin
         full <= 1'b0;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (load) begin
         held_bundle <= in_bundle;
      end
   end

endmodule

`default_nettype wire

// File: rtl/branch_handler.sv
`default_nettype none

module branch_handler
   import isa_pkg::*, fetch_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     rst_n,
   input  wire logic     held_valid,
   input  fetch_bundle_t held_bundle,
   input  wire logic     disp_space,
   input  commit_t       commit,
   output logic          take,
   output logic          disp_load,
   output dispatch_t     disp_data,
   output logic          adv_valid,
   output pc_t           adv_pc
);

   br_cnt_t    br_cnt;
   logic       hold;

   slot_mask_t is_jmp;
   slot_mask_t is_br;
   slot_mask_t refuse;
   slot_mask_t tkn;
   slot_mask_t zero;
   slot_mask_t pass;
   slot_mask_t upd;

   logic [2:0] n_pass;
   logic [2:0] n_upd;
   logic [2:0] cnt_sum;
   br_cnt_t    cnt_next;

   ////////////////////////////////////////
   // handshake
   ////////////////////////////////////////
   // bundle leaves the input register once dispatch has room
   assign take      = held_valid && disp_space;
   // under hold the bundle is dropped
   assign disp_load = take && !hold;
   assign adv_valid = take;

   ////////////////////////////////////////
   // slot decode
   ////////////////////////////////////////
   always_comb begin
      for (int i = 0; i < fetch_width; i++) begin
         is_jmp[i] = is_jump(held_bundle.inst[i]);
         is_br[i]  = is_branch(held_bundle.inst[i]);
      end
   end

   // walk slots oldest first
   always_comb begin : slot_walk
      logic [2:0] run;
      logic [2:0] loc;
      logic       dead;
      logic       pbit;
      // branches already in flight
      run  = {1'b0, br_cnt};
      // branches seen in this group
      loc  = '0;
      // hold kills the whole group
      dead = hold;
      for (int i = 0; i < fetch_width; i++) begin
         // third unresolved branch
         refuse[i] = is_br[i] && !dead && (run >= 3'(max_branches));
         // first branch of the group uses the upper prediction bit
         pbit      = (loc == 3'd0) ? held_bundle.pred[1] : held_bundle.pred[0];
         tkn[i]    = is_br[i] && !dead && !refuse[i] && pbit;
         zero[i]   = dead || refuse[i];
         // everything younger dies after a jump, taken branch or refusal
         dead      = dead || is_jmp[i] || tkn[i] || refuse[i];
         run       = run + 3'(is_br[i]);
         loc       = loc + 3'(is_br[i]);
      end
   end

   assign pass = ~zero;
   // predictor update for each surviving branch
   assign upd  = is_br & pass;

   // slot counts
   always_comb begin
      n_pass = '0;
      n_upd  = '0;
      for (int i = 0; i < fetch_width; i++) begin
         n_pass = n_pass + 3'(pass[i]);
         n_upd  = n_upd + 3'(upd[i]);
      end
   end

   // saturating increment
   assign cnt_sum  = {1'b0, br_cnt} + n_upd;
   assign cnt_next = (cnt_sum > 3'(max_branches)) ? br_cnt_t'(max_branches)
                                                   : cnt_sum[1:0];

   ////////////////////////////////////////
   // outputs to dispatch and pc unit
   ////////////////////////////////////////
   always_comb begin
      disp_data.pc    = held_bundle.pc;
      disp_data.taken = tkn;
      disp_data.upd   = upd;
      for (int i = 0; i < fetch_width; i++) begin
         disp_data.inst[i] = zero[i] ? nop_inst : held_bundle.inst[i];
      end
   end

   // restart right after the last passed slot
   assign adv_pc = held_bundle.pc + pc_t'(n_pass);

   ////////////////////////////////////////
   // branch counter and hold
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         br_cnt <= '0;
      end else if (commit.decr) begin
         // commit wins, same-cycle increment is lost
         if (commit.mispred_two) begin
            br_cnt <= (br_cnt >= 2'd2) ? br_cnt - 2'd2 : 2'd0;
         end else begin
            br_cnt <= (br_cnt != 2'd0) ? br_cnt - 2'd1 : 2'd0;
         end
      end else if (disp_load) begin
         br_cnt <= cnt_next;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hold <= 1'b0;
      end else if (commit.decr) begin
         hold <= 1'b0;
      end else if (disp_load && (|refuse)) begin
         hold <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/fetch_pc_unit.sv
`default_nettype none

module fetch_pc_unit
   import isa_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic adv_valid,
   input  pc_t       adv_pc,
   input  wire logic redirect_valid,
   input  pc_t       redirect_pc,
   output pc_t       fetch_pc
);

   ////////////////////////////////////////
   // fetch pc register
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_pc <= '0;
      end else if (redirect_valid) begin
         // taken target or flush beats the sequential advance
         fetch_pc <= redirect_pc;
      end else if (adv_valid) begin
         // group pc plus passed slots
         fetch_pc <= adv_pc;
      end
   end

endmodule

`default_nettype wire

// File: rtl/dispatch_out.sv
`default_nettype none

module dispatch_out
   import fetch_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic disp_load,
   input  dispatch_t disp_data,
   output logic      disp_space,
   input  wire logic out_ready,
   output logic      out_valid,
   output dispatch_t out_data
);

   // room when empty or decode takes the current group
   assign disp_space = !out_valid || out_ready;

   ////////////////////////////////////////
   // valid flag
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (disp_load) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // data only moves on a load, stable under back-pressure
   always_ff @(posedge clk) begin
      if (disp_load) begin
         out_data <= disp_data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
`default_nettype none

module fetch_top
   import isa_pkg::*, fetch_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     rst_n,
   input  wire logic     in_valid,
   input  fetch_bundle_t in_bundle,
   output logic          in_ready,
   input  commit_t       commit,
   input  wire logic     redirect_valid,
   input  pc_t           redirect_pc,
   output pc_t           fetch_pc,
   output logic          out_valid,
   input  wire logic     out_ready,
   output dispatch_t     out_data
);

   // input register to handler
   logic          held_valid;
   fetch_bundle_t held_bundle;
   logic          take;

   // handler to dispatch
   logic          disp_load;
   logic          disp_space;
   dispatch_t     disp_data;

   // handler to pc unit
   logic          adv_valid;
   pc_t           adv_pc;

   fetch_bundle_in fetch_bundle_in_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_bundle   (in_bundle),
      .in_ready    (in_ready),
      .take        (take),
      .held_valid  (held_valid),
      .held_bundle (held_bundle)
   );

   branch_handler branch_handler_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .held_valid  (held_valid),
      .held_bundle (held_bundle),
      .disp_space  (disp_space),
      .commit      (commit),
      .take        (take),
      .disp_load   (disp_load),
      .disp_data   (disp_data),
      .adv_valid   (adv_valid),
      .adv_pc      (adv_pc)
   );

   fetch_pc_unit fetch_pc_unit_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .adv_valid      (adv_valid),
      .adv_pc         (adv_pc),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .fetch_pc       (fetch_pc)
   );

   dispatch_out dispatch_out_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .disp_load  (disp_load),
      .disp_data  (disp_data),
      .disp_space (disp_space),
      .out_ready  (out_ready),
      .out_valid  (out_valid),
      .out_data   (out_data)
   );

endmodule

`default_nettype wire

// File: testbench/fetch_top_tb.sv
`default_nettype none

module fetch_top_tb
   import isa_pkg::*, fetch_pkg::*;
();

   localparam int num_steps  = 23;
   localparam int num_cols   = 21;
   // each step takes one cycle plus slack for reset and drain
   localparam int max_cycles = num_steps + 20;

   // column positions in one step line
   localparam int c_pc    = 1;
   localparam int c_inst  = 2;
   localparam int c_pred  = 6;
   localparam int c_ordy  = 7;
   localparam int c_decr  = 8;
   localparam int c_mis2  = 9;
   localparam int c_rv    = 10;
   localparam int c_rpc   = 11;
   localparam int c_exp   = 12;
   localparam int c_einst = 13;
   localparam int c_tkn   = 17;
   localparam int c_upd   = 18;
   localparam int c_epc   = 19;
   localparam int c_rdy   = 20;

   // one expected dispatch group in order of acceptance
   typedef struct packed {
      dispatch_t   data;
      pc_t         pc;
      logic [15:0] step;
   } expect_t;

   logic          clk;
   logic          rst_n;
   logic          in_valid;
   fetch_bundle_t in_bundle;
   logic          in_ready;
   commit_t       commit;
   logic          redirect_valid;
   pc_t           redirect_pc;
   pc_t           fetch_pc;
   logic          out_valid;
   logic          out_ready;
   dispatch_t     out_data;

   logic [15:0]   stim [num_steps*num_cols];
   expect_t       exp_q [$];
   int            cycles = 0;
   // back-pressure tracking
   logic          stalled;
   dispatch_t     stall_data;

   fetch_top fetch_top_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .in_valid       (in_valid),
      .in_bundle      (in_bundle),
      .in_ready       (in_ready),
      .commit         (commit),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .fetch_pc       (fetch_pc),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .out_data       (out_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("cycle limit of %0d reached with groups still pending", max_cycles);
         $display("tests failed");
         $fatal(1, "run stopped by cycle limit");
      end
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   task automatic check_value(input string name, input logic [127:0] exp_val,
                              input logic [127:0] act_val);
      if (exp_val !== act_val) begin
         $display("[ERROR] %s expected %0h actual %0h", name, exp_val, act_val);
         $display("tests failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // apply one step line and queue its expected group
   task automatic drive_step(input int k);
      int      b;
      expect_t e;
      b = k * num_cols;
      in_valid     = stim[b][0];
      in_bundle.pc = stim[b + c_pc];
      for (int i = 0; i < fetch_width; i++) begin
         in_bundle.inst[i] = stim[b + c_inst + i];
         e.data.inst[i]    = stim[b + c_einst + i];
      end
      in_bundle.pred     = stim[b + c_pred][1:0];
      out_ready          = stim[b + c_ordy][0];
      commit.decr        = stim[b + c_decr][0];
      commit.mispred_two = stim[b + c_mis2][0];
      redirect_valid     = stim[b + c_rv][0];
      redirect_pc        = stim[b + c_rpc];
      if (stim[b + c_exp][0]) begin
         e.data.pc    = stim[b + c_pc];
         e.data.taken = stim[b + c_tkn][3:0];
         e.data.upd   = stim[b + c_upd][3:0];
         e.pc         = stim[b + c_epc];
         e.step       = 16'(k);
         exp_q.push_back(e);
      end
   endtask

   // quiet inputs while the pipeline drains
   task automatic apply_idle();
      in_valid       = 1'b0;
      out_ready      = 1'b1;
      commit         = '0;
      redirect_valid = 1'b0;
   endtask

   // sampled mid-cycle
   task automatic watch_outputs();
      expect_t e;
      string   name;
      // a stalled group must not move
      if (stalled && out_valid) begin
         check_value("stable out_data", 128'(stall_data), 128'(out_data));
      end
      stalled    = out_valid && !out_ready;
      stall_data = out_data;
      if (out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("dispatch handed out a group that no step expected");
            $display("tests failed");
            $fatal(1, "unexpected output");
         end else begin
            e    = exp_q.pop_front();
            name = $sformatf("step %0d", e.step);
            check_value({name, " group pc"}, 128'(e.data.pc), 128'(out_data.pc));
            check_value({name, " words"}, 128'(e.data.inst), 128'(out_data.inst));
            check_value({name, " taken"}, 128'(e.data.taken), 128'(out_data.taken));
            check_value({name, " upd"}, 128'(e.data.upd), 128'(out_data.upd));
            check_value({name, " fetch_pc"}, 128'(e.pc), 128'(fetch_pc));
         end
      end
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      rst_n          = 1'b0;
      in_valid       = 1'b0;
      in_bundle      = '0;
      commit         = '0;
      redirect_valid = 1'b0;
      redirect_pc    = '0;
      out_ready      = 1'b0;
      stalled        = 1'b0;
      stall_data     = '0;
      $readmemh("testbench/fetch_input.txt", stim);
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      // state right after reset
      @(negedge clk);
      check_value("reset in_ready", 128'(1'b1), 128'(in_ready));
      check_value("reset out_valid", 128'(1'b0), 128'(out_valid));
      check_value("reset fetch_pc", 128'(16'h0000), 128'(fetch_pc));
      for (int k = 0; k < num_steps; k++) begin
         @(posedge clk);
         #1;
         drive_step(k);
         @(negedge clk);
         check_value($sformatf("step %0d in_ready", k),
                     128'(stim[k*num_cols + c_rdy][0]), 128'(in_ready));
         watch_outputs();
      end
      // groups still in flight
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #1;
         apply_idle();
         @(negedge clk);
         watch_outputs();
      end
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/fetch_input.txt
// in_valid pc inst0..3 pred out_ready decr mispred_two redirect_valid redirect_pc
// expect exp_inst0..3 exp_taken exp_upd exp_fetch_pc exp_in_ready
1 0010 1111 f020 2222 3333 0 1 0 0 0 0000 1 1111 f020 0000 0000 0 0 0012 1
1 0020 1111 9003 2222 3333 2 1 0 0 0 0000 1 1111 9003 0000 0000 2 2 0022 1
0 0000 0000 0000 0000 0000 0 1 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 1
1 0030 b001 1111 a002 2222 1 1 1 0 0 0000 1 b001 1111 a002 0000 4 5 0033 1
1 0040 1111 9001 2222 3333 0 1 0 0 0 0000 1 1111 0000 0000 0000 0 0 0041 1
1 0041 9002 1111 2222 3333 0 1 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 1
0 0000 0000 0000 0000 0000 0 1 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 1
1 0041 9002 1111 2222 3333 0 1 1 0 0 0000 1 9002 1111 2222 3333 0 1 0045 1
0 0000 0000 0000 0000 0000 0 1 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 1
1 0050 9001 a002 1111 2222 0 1 1 1 0 0000 1 9001 a002 1111 2222 0 3 0054 1
0 0000 0000 0000 0000 0000 0 1 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 1
1 0060 9001 1111 a001 2222 0 1 1 0 0 0000 1 9001 1111 0000 0000 0 1 0062 1
0 0000 0000 0000 0000 0000 0 1 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 1
0 0000 0000 0000 0000 0000 0 1 1 1 0 0000 0 0000 0000 0000 0000 0 0 0000 1
1 0062 a001 b002 1111 2222 0 1 1 0 0 0000 1 a001 b002 1111 2222 0 3 0066 1
1 0100 1111 2222 3333 4444 0 0 0 0 0 0000 1 1111 2222 3333 4444 0 0 0104 1
1 0104 5555 6666 7777 1234 0 0 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 0
1 0104 5555 6666 7777 1234 0 0 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 0
1 0104 5555 6666 7777 1234 0 1 0 0 0 0000 1 5555 6666 7777 1234 0 0 0108 1
0 0000 0000 0000 0000 0000 0 1 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 1
1 0200 4321 8765 f000 1111 0 1 0 0 0 0000 1 4321 8765 f000 0000 0 0 0300 1
0 0000 0000 0000 0000 0000 0 1 0 0 1 0300 0 0000 0000 0000 0000 0 0 0000 1
0 0000 0000 0000 0000 0000 0 1 0 0 0 0000 0 0000 0000 0000 0000 0 0 0000 1

// File: fetch_top.f
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_bundle_in.sv
rtl/branch_handler.sv
rtl/fetch_pc_unit.sv
rtl/dispatch_out.sv
rtl/fetch_top.sv
testbench/fetch_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module fetch_top_tb \
   -f fetch_top.f \
   -o fetch_top_tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/fetch_top_tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
